// ==== design/idu_isa_pkg.sv ====
// RV64 integer encodings only; the opcode list covers just the four classes that decode handles
package idu_isa_pkg;

  //======================================================================
  // Widths
  //======================================================================
  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int NUM_GPR   = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [ILEN-1:0]      inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  //======================================================================
  // Major opcodes, inst[6:0]
  //======================================================================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

endpackage

// ==== design/idu_pipe_pkg.sv ====
// Pipeline-side fields for two execution units only; compile after idu_isa_pkg
package idu_pipe_pkg;

  // One-hot unit select, zero means no unit
  localparam int EU_NUM = 2;
  localparam int EU_ALU = 0;
  localparam int EU_LSU = 1;

  typedef logic [EU_NUM-1:0] eu_sel_t;

  // funct7[5] on top of funct3
  localparam int FUNC_W = 4;

  typedef logic [FUNC_W-1:0] func_t;

  // Immediates are sign extended to the full data width
  typedef logic [idu_isa_pkg::XLEN-1:0] imm_t;

endpackage

// ==== design/idu_decoder.sv ====
// Decodes OP, OP-IMM, LOAD and STORE only; anything else is illegal with no operands or unit
`timescale 1ns/1ps

module idu_decoder (
  input  idu_isa_pkg::inst_t     inst,
  output idu_isa_pkg::reg_idx_t  src0_reg,
  output idu_isa_pkg::reg_idx_t  src1_reg,
  output idu_isa_pkg::reg_idx_t  dst_reg,
  output logic                   src0_vld,
  output logic                   src1_vld,
  output logic                   dst_vld,
  output logic                   illegal,
  output idu_pipe_pkg::eu_sel_t  eu_sel,
  output idu_pipe_pkg::func_t    func,
  output idu_pipe_pkg::imm_t     imm
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               rd_used;
  idu_pipe_pkg::imm_t imm_i;
  idu_pipe_pkg::imm_t imm_s;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign src0_reg = inst[19:15];
  assign src1_reg = inst[24:20];
  assign dst_reg  = inst[11:7];

  assign imm_i = {{(idu_isa_pkg::XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(idu_isa_pkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    src0_vld = 1'b0;
    src1_vld = 1'b0;
    rd_used  = 1'b0;
    illegal  = 1'b0;
    eu_sel   = '0;
    func     = {1'b0, funct3};
    imm      = '0;
    case (opcode)
      idu_isa_pkg::OPC_OP: begin
        src0_vld                   = 1'b1;
        src1_vld                   = 1'b1;
        rd_used                    = 1'b1;
        eu_sel[idu_pipe_pkg::EU_ALU] = 1'b1;
        // Only register ops carry funct7[5] (ADD/SUB, SRL/SRA)
        func                       = {inst[30], funct3};
      end
      idu_isa_pkg::OPC_OP_IMM: begin
        src0_vld                   = 1'b1;
        rd_used                    = 1'b1;
        eu_sel[idu_pipe_pkg::EU_ALU] = 1'b1;
        imm                        = imm_i;
      end
      idu_isa_pkg::OPC_LOAD: begin
        src0_vld                   = 1'b1;
        rd_used                    = 1'b1;
        eu_sel[idu_pipe_pkg::EU_LSU] = 1'b1;
        imm                        = imm_i;
      end
      idu_isa_pkg::OPC_STORE: begin
        src0_vld                   = 1'b1;
        src1_vld                   = 1'b1;
        eu_sel[idu_pipe_pkg::EU_LSU] = 1'b1;
        imm                        = imm_s;
      end
      default: illegal = 1'b1;
    endcase
  end

  // x0 as destination is never tracked
  assign dst_vld = rd_used & (dst_reg != '0);

endmodule

// ==== design/idu_gpr.sv ====
// Register contents are undefined until written; x0 reads zero and drops writes
`timescale 1ns/1ps

module idu_gpr (
  input  logic                   forever_cpuclk,
  input  logic                   wb_vld,
  input  idu_isa_pkg::reg_idx_t  wb_reg,
  input  idu_isa_pkg::xlen_t     wb_data,
  input  idu_isa_pkg::reg_idx_t  rd0_reg,
  input  idu_isa_pkg::reg_idx_t  rd1_reg,
  output idu_isa_pkg::xlen_t     rd0_data,
  output idu_isa_pkg::xlen_t     rd1_data
);

  // Entry 0 does not exist
  idu_isa_pkg::xlen_t regs [1:idu_isa_pkg::NUM_GPR-1];

  always_ff @(posedge forever_cpuclk) begin
    if (wb_vld && (wb_reg != '0)) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // No write bypass, a write shows up after its edge
  assign rd0_data = (rd0_reg == '0) ? '0 : regs[rd0_reg];
  assign rd1_data = (rd1_reg == '0) ? '0 : regs[rd1_reg];

endmodule

// ==== design/idu_wbt.sv ====
// One pending bit per register; a set and a clear of the same bit on one edge leaves it set
`timescale 1ns/1ps

module idu_wbt (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  logic                   dis_fire,
  input  logic                   flush,
  input  logic                   wb_vld,
  input  idu_isa_pkg::reg_idx_t  wb_reg,
  input  idu_isa_pkg::reg_idx_t  src0_reg,
  input  idu_isa_pkg::reg_idx_t  src1_reg,
  input  idu_isa_pkg::reg_idx_t  dst_reg,
  input  logic                   dst_vld,
  output logic                   src0_busy,
  output logic                   src1_busy,
  output logic                   dst_busy
);

  logic [idu_isa_pkg::NUM_GPR-1:0] pend;
  logic [idu_isa_pkg::NUM_GPR-1:0] set_vec;
  logic [idu_isa_pkg::NUM_GPR-1:0] clr_vec;

  always_comb begin
    set_vec = '0;
    clr_vec = '0;
    if (dis_fire && dst_vld) begin
      set_vec[dst_reg] = 1'b1;
    end
    if (wb_vld) begin
      clr_vec[wb_reg] = 1'b1;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      pend <= '0;
    end else if (flush) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~clr_vec) | set_vec;
    end
  end

  assign src0_busy = pend[src0_reg];
  assign src1_busy = pend[src1_reg];
  assign dst_busy  = pend[dst_reg];

endmodule

// ==== design/idu_ctrl.sv ====
// Single issue with no operand forwarding; an illegal instruction is never held by a full unit
`timescale 1ns/1ps

module idu_ctrl (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  logic                   inst_vld,
  input  logic                   flush,
  input  logic                   alu_full,
  input  logic                   lsu_full,
  input  logic                   src0_vld,
  input  logic                   src1_vld,
  input  logic                   dst_vld,
  input  logic                   illegal,
  input  idu_pipe_pkg::eu_sel_t  eu_sel,
  input  logic                   src0_busy,
  input  logic                   src1_busy,
  input  logic                   dst_busy,
  output logic                   dis_fire,
  output logic                   id_stall,
  output logic                   ex1_inst_vld,
  output logic                   ex1_alu_sel,
  output logic                   ex1_lsu_sel,
  output logic                   ex1_illegal
);

  logic reg_hazard;
  logic unit_full;

  //======================================================================
  // Dispatch decision
  //======================================================================
  assign reg_hazard = (src0_vld & src0_busy)
                    | (src1_vld & src1_busy)
                    | (dst_vld  & dst_busy);

  // Illegal instructions select no unit so this stays low for them
  assign unit_full = (eu_sel[idu_pipe_pkg::EU_ALU] & alu_full)
                   | (eu_sel[idu_pipe_pkg::EU_LSU] & lsu_full);

  assign dis_fire = inst_vld & ~flush & ~reg_hazard & ~unit_full;
  assign id_stall = inst_vld & ~dis_fire;

  //======================================================================
  // EX1 control
  //======================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      ex1_inst_vld <= 1'b0;
      ex1_alu_sel  <= 1'b0;
      ex1_lsu_sel  <= 1'b0;
      ex1_illegal  <= 1'b0;
    end else begin
      ex1_inst_vld <= dis_fire;
      ex1_alu_sel  <= dis_fire & eu_sel[idu_pipe_pkg::EU_ALU];
      ex1_lsu_sel  <= dis_fire & eu_sel[idu_pipe_pkg::EU_LSU];
      ex1_illegal  <= dis_fire & illegal;
    end
  end

endmodule

// ==== design/idu_dp.sv ====
// EX1 payload is only meaningful while ex1_inst_vld is high
`timescale 1ns/1ps

module idu_dp (
  input  logic                   forever_cpuclk,
  input  logic                   dis_fire,
  input  idu_isa_pkg::xlen_t     rd0_data,
  input  idu_isa_pkg::xlen_t     rd1_data,
  input  idu_pipe_pkg::func_t    func,
  input  idu_pipe_pkg::imm_t     imm,
  input  idu_isa_pkg::reg_idx_t  dst_reg,
  input  logic                   dst_vld,
  output idu_isa_pkg::xlen_t     ex1_src0_data,
  output idu_isa_pkg::xlen_t     ex1_src1_data,
  output idu_pipe_pkg::func_t    ex1_func,
  output idu_pipe_pkg::imm_t     ex1_imm,
  output idu_isa_pkg::reg_idx_t  ex1_dst_reg,
  output logic                   ex1_dst_vld
);

  //======================================================================
  // EX1 operand registers
  //======================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (dis_fire) begin
      ex1_src0_data <= rd0_data;
      ex1_src1_data <= rd1_data;
    end
  end

  // Function, immediate and destination
  always_ff @(posedge forever_cpuclk) begin
    if (dis_fire) begin
      ex1_func    <= func;
      ex1_imm     <= imm;
      ex1_dst_reg <= dst_reg;
      ex1_dst_vld <= dst_vld;
    end
  end

endmodule

// ==== design/idu_top.sv ====
// Decode stage for one ALU and one LSU; fetch must hold inst_vld and inst while id_stall is high
`timescale 1ns/1ps

module idu_top (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  logic                   inst_vld,
  input  idu_isa_pkg::inst_t     inst,
  input  logic                   wb_vld,
  input  idu_isa_pkg::reg_idx_t  wb_reg,
  input  idu_isa_pkg::xlen_t     wb_data,
  input  logic                   alu_full,
  input  logic                   lsu_full,
  input  logic                   flush,
  output logic                   id_stall,
  output logic                   ex1_inst_vld,
  output logic                   ex1_alu_sel,
  output logic                   ex1_lsu_sel,
  output logic                   ex1_illegal,
  output idu_pipe_pkg::func_t    ex1_func,
  output idu_isa_pkg::reg_idx_t  ex1_dst_reg,
  output logic                   ex1_dst_vld,
  output idu_isa_pkg::xlen_t     ex1_src0_data,
  output idu_isa_pkg::xlen_t     ex1_src1_data,
  output idu_pipe_pkg::imm_t     ex1_imm
);

  // Decoded fields
  idu_isa_pkg::reg_idx_t src0_reg;
  idu_isa_pkg::reg_idx_t src1_reg;
  idu_isa_pkg::reg_idx_t dst_reg;
  logic                  src0_vld;
  logic                  src1_vld;
  logic                  dst_vld;
  logic                  illegal;
  idu_pipe_pkg::eu_sel_t eu_sel;
  idu_pipe_pkg::func_t   func;
  idu_pipe_pkg::imm_t    imm;

  // Scoreboard, dispatch and operands
  logic                  src0_busy;
  logic                  src1_busy;
  logic                  dst_busy;
  logic                  dis_fire;
  idu_isa_pkg::xlen_t    rd0_data;
  idu_isa_pkg::xlen_t    rd1_data;

  //======================================================================
  // Decode stage modules
  //======================================================================
  idu_decoder x_idu_decoder (.*);

  // Read ports follow the decoded source indices
  idu_gpr x_idu_gpr (
    .rd0_reg (src0_reg),
    .rd1_reg (src1_reg),
    .*
  );

  idu_wbt x_idu_wbt (.*);

  idu_ctrl x_idu_ctrl (.*);

  idu_dp x_idu_dp (.*);

endmodule

// ==== bench/idu_properties.sv ====
// Checks on idu_top ports at the rising clock; unit-select checks are off while rst_n is low
`timescale 1ns/1ps

module idu_properties (
  input logic forever_cpuclk,
  input logic rst_n,
  input logic flush,
  input logic ex1_inst_vld,
  input logic ex1_alu_sel,
  input logic ex1_lsu_sel
);

  int fail_count = 0;

  sel_onehot_a: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    !(ex1_alu_sel && ex1_lsu_sel))
    else begin
      fail_count++;
      $error("ex1_alu_sel and ex1_lsu_sel high together");
    end

  // A unit select needs a valid EX1 instruction
  sel_needs_vld_a: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    (ex1_alu_sel || ex1_lsu_sel) |-> ex1_inst_vld)
    else begin
      fail_count++;
      $error("unit select high without ex1_inst_vld");
    end

  flush_kills_a: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    flush |=> !ex1_inst_vld)
    else begin
      fail_count++;
      $error("ex1_inst_vld high in the cycle after flush");
    end

endmodule

bind idu_top idu_properties u_props (.*);

// ==== bench/tb_top.sv ====
// Fixed seed 15; operand data is compared only after every GPR has been written once
`timescale 1ns/1ps

module tb_top;

  logic                  forever_cpuclk, rst_n, inst_vld, wb_vld, alu_full, lsu_full, flush;
  idu_isa_pkg::inst_t    inst;
  idu_isa_pkg::reg_idx_t wb_reg, ex1_dst_reg;
  idu_isa_pkg::xlen_t    wb_data, ex1_src0_data, ex1_src1_data;
  logic                  id_stall, ex1_inst_vld, ex1_alu_sel, ex1_lsu_sel, ex1_illegal;
  logic                  ex1_dst_vld;
  idu_pipe_pkg::func_t   ex1_func;
  idu_pipe_pkg::imm_t    ex1_imm;

  // Reference model state
  idu_isa_pkg::xlen_t    mregs [idu_isa_pkg::NUM_GPR];
  logic [31:0]           mpend;

  idu_top u_dut (.*);

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #10 forever_cpuclk = ~forever_cpuclk;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // Bound assertion failures end the run at once
  always @(u_dut.u_props.fail_count) begin
    if (u_dut.u_props.fail_count != 0) begin
      $display("Finished with errors");
      $fatal(1, "concurrent assertion failed");
    end
  end

  function automatic idu_isa_pkg::inst_t make_inst(input logic [6:0] opc);
    idu_isa_pkg::inst_t r;
    r = $urandom;
    return {r[31:7], opc};
  endfunction

  //====================================================================
  // One clock from falling edge to falling edge
  //====================================================================
  task automatic clock_cycle;
    logic                alu, lsu, ill, s0v, s1v, dv, fire;
    logic [4:0]          rs1, rs2, rd;
    idu_pipe_pkg::imm_t  imm;
    idu_pipe_pkg::func_t fn;
    #5;
    {rs2, rs1} = inst[24:15];
    rd = inst[11:7];
    {alu, lsu, ill, s0v, s1v, dv} = '0;
    imm = '0;
    fn  = {1'b0, inst[14:12]};
    case (inst[6:0])
      idu_isa_pkg::OPC_OP: begin
        {alu, s0v, s1v, dv} = '1;
        fn[3] = inst[30];
      end
      idu_isa_pkg::OPC_OP_IMM: begin
        {alu, s0v, dv} = '1;
        imm = {{52{inst[31]}}, inst[31:20]};
      end
      idu_isa_pkg::OPC_LOAD: begin
        {lsu, s0v, dv} = '1;
        imm = {{52{inst[31]}}, inst[31:20]};
      end
      idu_isa_pkg::OPC_STORE: begin
        {lsu, s0v, s1v} = '1;
        imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      end
      default: ill = 1'b1;
    endcase
    dv   = dv && (rd != 5'd0);
    fire = inst_vld && !flush && !(s0v && mpend[rs1]) && !(s1v && mpend[rs2])
           && !(dv && mpend[rd]) && !(alu && alu_full) && !(lsu && lsu_full);
    check_value("id_stall", id_stall, inst_vld && !fire);
    @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    check_value("ex1_inst_vld", ex1_inst_vld, fire);
    check_value("ex1_alu_sel", ex1_alu_sel, fire && alu);
    check_value("ex1_lsu_sel", ex1_lsu_sel, fire && lsu);
    check_value("ex1_illegal", ex1_illegal, fire && ill);
    if (fire) begin
      check_value("ex1_src0_data", ex1_src0_data, mregs[rs1]);
      check_value("ex1_src1_data", ex1_src1_data, mregs[rs2]);
      check_value("ex1_func", ex1_func, fn);
      check_value("ex1_imm", ex1_imm, imm);
      check_value("ex1_dst_reg", ex1_dst_reg, rd);
      check_value("ex1_dst_vld", ex1_dst_vld, dv);
    end
    // Model follows the edge that just passed, set wins over clear
    if (!rst_n || flush) begin
      mpend = '0;
    end else begin
      if (wb_vld) mpend[wb_reg] = 1'b0;
      if (fire && dv) mpend[rd] = 1'b1;
    end
    if (wb_vld && (wb_reg != 5'd0)) mregs[wb_reg] = wb_data;
  endtask

  task automatic write_back(input idu_isa_pkg::reg_idx_t r);
    wb_vld  = 1'b1;
    wb_reg  = r;
    wb_data = {$urandom, $urandom};
    clock_cycle();
    wb_vld = 1'b0;
  endtask

  task automatic present_inst(input idu_isa_pkg::inst_t w, input int cycles);
    inst_vld = 1'b1;
    inst     = w;
    repeat (cycles) clock_cycle();
  endtask

  // Hold w until EX1 shows it, then write back its rd if asked
  task automatic run_inst(input idu_isa_pkg::inst_t w, input logic retire);
    int n;
    n = 0;
    present_inst(w, 1);
    while (!ex1_inst_vld) begin
      n++;
      if (n > 20) begin
        $display("Timed out waiting for instruction 0x%h to dispatch", w);
        $display("Finished with errors");
        $fatal(1, "dispatch timeout");
      end
      clock_cycle();
    end
    inst_vld = 1'b0;
    if (retire) write_back(w[11:7]);
  endtask

  //====================================================================
  // Test sequence
  //====================================================================
  initial begin
    idu_isa_pkg::inst_t w;
    logic [6:0]         opcs [5];
    void'($urandom(15));
    {rst_n, inst_vld, wb_vld, alu_full, lsu_full, flush} = '0;
    inst     = '0;
    wb_reg   = '0;
    wb_data  = '0;
    mregs[0] = '0;
    mpend    = '0;
    repeat (16) clock_cycle();
    rst_n = 1'b1;
    repeat (2) clock_cycle();

    // Fill the register file, x0 included, then decode every class
    for (int r = 0; r < idu_isa_pkg::NUM_GPR; r++) write_back(r[4:0]);
    opcs = '{idu_isa_pkg::OPC_OP, idu_isa_pkg::OPC_OP_IMM, idu_isa_pkg::OPC_LOAD,
             idu_isa_pkg::OPC_STORE, 7'b1101111};
    for (int k = 0; k < 25; k++) begin
      w = make_inst(opcs[k % 5]);
      if (k == 0) w[24:15] = '0;
      run_inst(w, 1'b1);
    end

    // RAW on x5
    w = make_inst(idu_isa_pkg::OPC_OP_IMM);
    w[11:7] = 5'd5;
    run_inst(w, 1'b0);
    w = make_inst(idu_isa_pkg::OPC_OP);
    w[19:15] = 5'd5;
    w[11:7]  = 5'd6;
    present_inst(w, 3);
    write_back(5'd5);
    run_inst(w, 1'b0);

    // WAW on x6 with no busy source
    w = make_inst(idu_isa_pkg::OPC_LOAD);
    w[19:15] = 5'd0;
    w[11:7]  = 5'd6;
    present_inst(w, 2);
    write_back(5'd6);
    run_inst(w, 1'b1);

    // Unit back-pressure
    alu_full = 1'b1;
    run_inst(make_inst(idu_isa_pkg::OPC_LOAD), 1'b1);
    w = make_inst(idu_isa_pkg::OPC_OP);
    present_inst(w, 3);
    alu_full = 1'b0;
    run_inst(w, 1'b1);
    lsu_full = 1'b1;
    w = make_inst(idu_isa_pkg::OPC_STORE);
    present_inst(w, 2);
    lsu_full = 1'b0;
    run_inst(w, 1'b0);
    {alu_full, lsu_full} = 2'b11;
    run_inst(make_inst(7'b1111111), 1'b0);
    {alu_full, lsu_full} = 2'b00;

    // Flush while waiting on x7
    w = make_inst(idu_isa_pkg::OPC_LOAD);
    w[11:7] = 5'd7;
    run_inst(w, 1'b0);
    w = make_inst(idu_isa_pkg::OPC_STORE);
    w[24:15] = {5'd7, 5'd0};
    present_inst(w, 2);
    flush = 1'b1;
    clock_cycle();
    flush = 1'b0;
    run_inst(w, 1'b0);

    // Flush also cancels an instruction free to dispatch
    w = make_inst(idu_isa_pkg::OPC_OP_IMM);
    flush = 1'b1;
    present_inst(w, 1);
    flush = 1'b0;
    run_inst(w, 1'b1);
    repeat (2) clock_cycle();

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/idu_isa_pkg.sv
design/idu_pipe_pkg.sv
design/idu_decoder.sv
design/idu_gpr.sv
design/idu_wbt.sv
design/idu_ctrl.sv
design/idu_dp.sv
design/idu_top.sv
bench/idu_properties.sv
bench/tb_top.sv

// ==== Bender.yml ====
package:
  name: idu_decode

sources:
  - design/idu_isa_pkg.sv
  - design/idu_pipe_pkg.sv
  - design/idu_decoder.sv
  - design/idu_gpr.sv
  - design/idu_wbt.sv
  - design/idu_ctrl.sv
  - design/idu_dp.sv
  - design/idu_top.sv
  - target: simulation
    files:
      - bench/idu_properties.sv
      - bench/tb_top.sv
